//--- verification/mips_vectors.hex
// columns: expected ir_addr, instruction word, expected rf_write, expected rf_writedata
// rf_writedata is only compared when rf_write is expected high
00000000 20010005 00000001 00000005 // addi $1, $0, 5
00000004 2002000C 00000001 0000000C // addi $2, $0, 12
00000008 00221820 00000001 00000011 // add  $3, $1, $2
0000000C 00412022 00000001 00000007 // sub  $4, $2, $1
00000010 00222824 00000001 00000004 // and  $5, $1, $2
00000014 00223025 00000001 0000000D // or   $6, $1, $2
00000018 0022382A 00000001 00000001 // slt  $7, $1, $2
0000001C 0041402A 00000001 00000000 // slt  $8, $2, $1
00000020 2009FFFF 00000001 FFFFFFFF // addi $9, $0, -1
00000024 0029502A 00000001 00000001 // slt  $10, $1, $9  unsigned compare
00000028 20000007 00000001 00000007 // addi $0, $0, 7  write dropped
0000002C 00015820 00000001 00000005 // add  $11, $0, $1  $0 still zero
00000030 AC030008 00000000 00000000 // sw   $3, 8($0)
00000034 8C0C0008 00000001 00000011 // lw   $12, 8($0)
00000038 8C0D0010 00000001 00000000 // lw   $13, 16($0)  never written
0000003C 102B0002 00000000 00000000 // beq  $1, $11, +2  taken
00000048 10220005 00000000 00000000 // beq  $1, $2, +5  not taken
0000004C 08000018 00000000 00000000 // j    0x60
00000060 0C000020 00000001 00000064 // jal  0x80
00000080 23EE0000 00000001 00000064 // addi $14, $31, 0
00000084 03E00008 00000000 00000000 // jr   $31
00000064 200F0123 00000001 00000123 // addi $15, $0, 0x123
00000068 AC4F0000 00000000 00000000 // sw   $15, 0($2)
0000006C 8C10000C 00000001 00000123 // lw   $16, 12($0)
00000070 8C51FFFC 00000001 00000011 // lw   $17, -4($2)
00000074 1000FFFF 00000000 00000000 // beq  $0, $0, -1  spin
00000074 1000FFFF 00000000 00000000 // beq  $0, $0, -1  spin

//--- mips_system.f
verilog/mips_isa_pkg.sv
verilog/mips_ctrl_pkg.sv
verilog/mips_decoder.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_core.sv
verilog/mips_data_sram.sv
verilog/mips_system.sv
verification/tb_mips_system.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_mips_system
FILELIST   := mips_system.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_mips_system.sv
// Vector-driven testbench for the MIPS subsystem.
// Each record gives the expected fetch address, the instruction to feed back,
// and the expected writeback strobe and data for that cycle.

`timescale 1ns/100ps

module tb_mips_system;

    localparam int    clk_half      = 4;
    localparam int    reset_cycles  = 16;
    localparam int    reset_timeout = 8;
    localparam int    max_records   = 64;
    localparam string vector_file   = "verification/mips_vectors.hex";

    logic        clk;
    logic        rst_n;
    logic [31:0] ir;
    logic [31:0] ir_addr;
    logic        rf_write;
    logic [31:0] rf_writedata;

    // each record is four words of pc, instruction, write strobe and write data
    logic [31:0] vec_mem [0:4*max_records-1];
    int          num_records;

    mips_system #(
        .dmem_addr_w (7)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir_addr      (ir_addr),
        .ir           (ir),
        .rf_write     (rf_write),
        .rf_writedata (rf_writedata)
    );

    always #clk_half clk = ~clk;

    // ========================================================================
    // failure reporting and compare
    // ========================================================================
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    // ========================================================================
    // vector file
    // ========================================================================
    task automatic load_vectors;
        int fd;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            stop_with_failure({"cannot open vector file ", vector_file});
        end
        $fclose(fd);

        // unused slots get a pattern whose strobe field is never 0 or 1
        for (int i = 0; i < 4*max_records; i++) begin
            vec_mem[i] = ~i;
        end
        $readmemh(vector_file, vec_mem);

        num_records = 0;
        while (num_records < max_records &&
               !$isunknown({vec_mem[4*num_records], vec_mem[4*num_records+1],
                            vec_mem[4*num_records+2], vec_mem[4*num_records+3]}) &&
               vec_mem[4*num_records+2] <= 32'd1) begin
            num_records++;
        end
        if (num_records == 0) begin
            stop_with_failure({"vector file holds no complete records: ", vector_file});
        end
        $display("loaded %0d records", num_records);
    endtask

    // ========================================================================
    // reset and per-cycle checks
    // ========================================================================
    // returns at a falling edge with pc already cleared
    task automatic wait_for_reset_state;
        int waited;
        waited = 0;
        @(negedge clk);
        while (ir_addr !== 32'h0) begin
            if (waited >= reset_timeout) begin
                stop_with_failure("timeout: ir_addr never cleared to zero during reset");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // called at a falling edge before the rising edge that commits the instruction
    task automatic apply_record(input int r);
        int base;
        base = 4 * r;
        check_value($sformatf("record %0d ir_addr", r), ir_addr, vec_mem[base]);
        ir = vec_mem[base+1];
        // let the combinational datapath settle
        #1;
        check_value($sformatf("record %0d rf_write", r), {31'b0, rf_write},
                    vec_mem[base+2]);
        if (vec_mem[base+2] == 32'd1) begin
            check_value($sformatf("record %0d rf_writedata", r), rf_writedata,
                        vec_mem[base+3]);
        end
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        ir    = '0;

        load_vectors();

        repeat (reset_cycles) @(posedge clk);
        wait_for_reset_state();
        rst_n = 1'b1;

        for (int r = 0; r < num_records; r++) begin
            apply_record(r);
            @(negedge clk);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- verilog/mips_system.sv
// Top level of the MIPS subsystem: core plus data SRAM.
// Instruction fetch and the writeback strobe are brought out for the testbench.

`timescale 1ns/100ps

module mips_system #(
    parameter int dmem_addr_w = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [mips_isa_pkg::xlen-1:0] ir_addr,
    input  logic [mips_isa_pkg::xlen-1:0] ir,
    output logic                          rf_write,
    output logic [mips_isa_pkg::xlen-1:0] rf_writedata
);

    import mips_isa_pkg::*;

    // core to SRAM
    logic                   cen;
    logic                   wen;
    logic                   oen;
    logic [dmem_addr_w-1:0] mem_addr;
    logic [xlen-1:0]        mem_wdata;
    logic [xlen-1:0]        mem_rdata;

    mips_core #(
        .dmem_addr_w (dmem_addr_w)
    ) u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir           (ir),
        .mem_rdata    (mem_rdata),
        .ir_addr      (ir_addr),
        .rf_write     (rf_write),
        .rf_writedata (rf_writedata),
        .cen          (cen),
        .wen          (wen),
        .oen          (oen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    mips_data_sram #(
        .dmem_addr_w (dmem_addr_w)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .wen   (wen),
        .oen   (oen),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

//--- verilog/mips_data_sram.sv
// Word-addressed data SRAM with active-low chip, write and output enables.
// Write at the rising edge, combinational read, cleared by reset.

`timescale 1ns/100ps

module mips_data_sram #(
    parameter int dmem_addr_w = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  logic                          wen,
    input  logic                          oen,
    input  logic [dmem_addr_w-1:0]        addr,
    input  logic [mips_isa_pkg::xlen-1:0] wdata,
    output logic [mips_isa_pkg::xlen-1:0] rdata
);

    import mips_isa_pkg::*;

    localparam int depth = 2 ** dmem_addr_w;

    logic [xlen-1:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (!cen && !wen) begin
            mem[addr] <= wdata;
        end
    end

    // bus reads zero when not selected
    assign rdata = (!cen && !oen) ? mem[addr] : '0;

    a_no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !cen |-> !(!wen && !oen)
    ) else $error("data SRAM read and write strobes both active");

endmodule

//--- verilog/mips_core.sv
// Single-cycle MIPS core: pc, decode, register file, ALU and writeback.
// Fetches one instruction per cycle from the ir port and drives the
// active-low strobes of an external data SRAM.

`timescale 1ns/100ps

module mips_core #(
    parameter int dmem_addr_w = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mips_isa_pkg::xlen-1:0] ir,
    input  logic [mips_isa_pkg::xlen-1:0] mem_rdata,
    output logic [mips_isa_pkg::xlen-1:0] ir_addr,
    output logic                          rf_write,
    output logic [mips_isa_pkg::xlen-1:0] rf_writedata,
    output logic                          cen,
    output logic                          wen,
    output logic                          oen,
    output logic [dmem_addr_w-1:0]        mem_addr,
    output logic [mips_isa_pkg::xlen-1:0] mem_wdata
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    // ========================================================================
    // declarations
    // ========================================================================
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      pc_next;
    logic [xlen-1:0]      pc_plus4;
    logic [xlen-1:0]      branch_target;
    logic [xlen-1:0]      jump_target;

    logic [opcode_w-1:0]  opcode;
    logic [funct_w-1:0]   funct;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic [reg_idx_w-1:0] rd;
    logic [imm_w-1:0]     imm;
    logic [target_w-1:0]  target;
    logic [xlen-1:0]      imm_ext;

    logic                 reg_dst;
    logic                 alu_src;
    logic                 mem_to_reg;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 branch;
    logic                 jump;
    logic                 link;
    logic                 jump_reg;
    alu_op_t              alu_op;

    logic [xlen-1:0]      rs_data;
    logic [xlen-1:0]      rt_data;
    logic [xlen-1:0]      alu_b;
    logic [xlen-1:0]      alu_result;
    logic                 alu_zero;
    logic [reg_idx_w-1:0] wr_reg;
    logic [xlen-1:0]      load_or_alu;
    logic [xlen-1:0]      wr_data;

    // instruction fields
    assign opcode  = ir[op_lsb +: opcode_w];
    assign funct   = ir[funct_lsb +: funct_w];
    assign rs      = ir[rs_lsb +: reg_idx_w];
    assign rt      = ir[rt_lsb +: reg_idx_w];
    assign rd      = ir[rd_lsb +: reg_idx_w];
    assign imm     = ir[imm_w-1:0];
    assign target  = ir[target_w-1:0];
    assign imm_ext = {{(xlen-imm_w){imm[imm_w-1]}}, imm};

    mips_decoder u_decoder (
        .opcode     (opcode),
        .funct      (funct),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .link       (link),
        .jump_reg   (jump_reg),
        .alu_op     (alu_op)
    );

    mips_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (rs),
        .rd_addr2 (rt),
        .wr_addr  (wr_reg),
        .write    (reg_write),
        .wr_data  (wr_data),
        .rd_data1 (rs_data),
        .rd_data2 (rt_data)
    );

    assign alu_b = alu_src ? imm_ext : rt_data;

    mips_alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ========================================================================
    // writeback
    // ========================================================================
    assign wr_reg       = link ? ra_index : (reg_dst ? rd : rt);
    assign load_or_alu  = mem_to_reg ? mem_rdata : alu_result;
    assign wr_data      = link ? pc_plus4 : load_or_alu;
    assign rf_write     = reg_write;
    assign rf_writedata = wr_data;

    // active-low data SRAM strobes
    assign cen       = !(mem_read || mem_write);
    assign wen       = !mem_write;
    assign oen       = !mem_read;
    assign mem_addr  = alu_result[dmem_addr_w+1:2];
    assign mem_wdata = rt_data;

    // ========================================================================
    // program counter
    // ========================================================================
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[xlen-3:0], 2'b00};
    // region of pc+4 with the word target below it
    assign jump_target   = {pc_plus4[xlen-1:target_w+2], target, 2'b00};

    always_comb begin
        if (jump_reg) begin
            pc_next = rs_data;
        end else if (jump) begin
            pc_next = jump_target;
        end else if (branch && alu_zero) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign ir_addr = pc;

    // jr through a register with low bits set would misalign fetch
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        ##1 pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

    // only lw and sw may select the data SRAM
    a_cen_only_on_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        !cen |-> (opcode == op_lw || opcode == op_sw)
    ) else $error("data SRAM enabled without a memory instruction");

endmodule

//--- verilog/mips_regfile.sv
// General register file for the single-cycle MIPS core.
// Two combinational read ports and one write port taken at the rising edge.
// Register 0 reads as zero and ignores writes.

`timescale 1ns/100ps

module mips_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [mips_isa_pkg::reg_idx_w-1:0] rd_addr1,
    input  logic [mips_isa_pkg::reg_idx_w-1:0] rd_addr2,
    input  logic [mips_isa_pkg::reg_idx_w-1:0] wr_addr,
    input  logic                               write,
    input  logic [mips_isa_pkg::xlen-1:0]      wr_data,
    output logic [mips_isa_pkg::xlen-1:0]      rd_data1,
    output logic [mips_isa_pkg::xlen-1:0]      rd_data2
);

    import mips_isa_pkg::*;

    // no storage behind register 0
    logic [xlen-1:0] regs [1:31];

    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // a write strobe with an X address would corrupt an unknown register
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        write |-> !$isunknown(wr_addr)
    ) else $error("regfile write with unknown address");

endmodule

//--- verilog/mips_alu.sv
// 32-bit ALU for the single-cycle MIPS core.
// Add, subtract, and, or and unsigned set-less-than, plus a zero flag for beq.

`timescale 1ns/100ps

module mips_alu (
    input  logic [mips_isa_pkg::xlen-1:0] a,
    input  logic [mips_isa_pkg::xlen-1:0] b,
    input  mips_ctrl_pkg::alu_op_t        op,
    output logic [mips_isa_pkg::xlen-1:0] result,
    output logic                          zero
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            // unsigned compare
            alu_slt: result = {{(xlen-1){1'b0}}, (a < b)};
            default: result = '0;
        endcase
    end

    // beq relies on this after a subtract
    assign zero = (result == '0);

endmodule

//--- verilog/mips_decoder.sv
// Main control and ALU control for the single-cycle MIPS core.
// Purely combinational. Turns opcode and funct into datapath control levels.

`timescale 1ns/100ps

module mips_decoder (
    input  logic [mips_isa_pkg::opcode_w-1:0] opcode,
    input  logic [mips_isa_pkg::funct_w-1:0]  funct,
    output logic                              reg_dst,
    output logic                              alu_src,
    output logic                              mem_to_reg,
    output logic                              reg_write,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic                              branch,
    output logic                              jump,
    output logic                              link,
    output logic                              jump_reg,
    output mips_ctrl_pkg::alu_op_t            alu_op
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    alu_class_t alu_class;

    // ========================================================================
    // main control
    // ========================================================================
    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        link       = 1'b0;
        jump_reg   = 1'b0;
        alu_class  = cls_add;

        case (opcode)
            op_rtype: begin
                reg_dst   = 1'b1;
                alu_class = cls_funct;
                // jr is the only R-type that writes no register
                if (funct == fn_jr) begin
                    jump_reg = 1'b1;
                end else begin
                    reg_write = 1'b1;
                end
            end
            op_addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            op_lw: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
            end
            op_sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            op_beq: begin
                branch    = 1'b1;
                alu_class = cls_sub;
            end
            op_j: begin
                jump = 1'b1;
            end
            op_jal: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            // unknown opcode behaves as a nop
            default: ;
        endcase
    end

    // ========================================================================
    // ALU control
    // ========================================================================
    always_comb begin
        case (alu_class)
            cls_sub: alu_op = alu_sub;
            cls_funct: begin
                case (funct)
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: alu_op = alu_add;
                endcase
            end
            default: alu_op = alu_add;
        endcase
    end

endmodule

//--- verilog/mips_ctrl_pkg.sv
// Control encodings shared by the instruction decoder and the ALU.
// The decoder picks an ALU class per opcode and turns it into an ALU operation.

package mips_ctrl_pkg;

    // ========================================================================
    // ALU operation
    // ========================================================================
    // same code points as the classic MIPS ALU control
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111
    } alu_op_t;

    // ========================================================================
    // ALU class from the main decode
    // ========================================================================
    // cls_add    address calc for lw/sw, and addi
    // cls_sub    compare for beq
    // cls_funct  R-type, resolved from funct
    typedef enum logic [1:0] {
        cls_add   = 2'b00,
        cls_sub   = 2'b01,
        cls_funct = 2'b10
    } alu_class_t;

endpackage

//--- verilog/mips_isa_pkg.sv
// MIPS instruction set constants for the single-cycle core.
// Holds the opcode and funct encodings and the bit positions of the instruction fields.
// Import it wherever an instruction word is taken apart or decoded.

package mips_isa_pkg;

    // ========================================================================
    // widths and field positions
    // ========================================================================
    localparam int xlen      = 32;
    localparam int opcode_w  = 6;
    localparam int funct_w   = 6;
    localparam int reg_idx_w = 5;
    localparam int imm_w     = 16;
    localparam int target_w  = 26;

    // lsb of each field in the instruction word
    localparam int op_lsb    = 26;
    localparam int rs_lsb    = 21;
    localparam int rt_lsb    = 16;
    localparam int rd_lsb    = 11;
    localparam int funct_lsb = 0;

    // jal link register
    localparam logic [reg_idx_w-1:0] ra_index = 5'd31;

    // ========================================================================
    // opcodes
    // ========================================================================
    localparam logic [opcode_w-1:0] op_rtype = 6'b000000;
    localparam logic [opcode_w-1:0] op_addi  = 6'b001000;
    localparam logic [opcode_w-1:0] op_lw    = 6'b100011;
    localparam logic [opcode_w-1:0] op_sw    = 6'b101011;
    localparam logic [opcode_w-1:0] op_beq   = 6'b000100;
    localparam logic [opcode_w-1:0] op_j     = 6'b000010;
    localparam logic [opcode_w-1:0] op_jal   = 6'b000011;

    // R-type funct codes
    localparam logic [funct_w-1:0] fn_add = 6'b100000;
    localparam logic [funct_w-1:0] fn_sub = 6'b100010;
    localparam logic [funct_w-1:0] fn_and = 6'b100100;
    localparam logic [funct_w-1:0] fn_or  = 6'b100101;
    localparam logic [funct_w-1:0] fn_slt = 6'b101010;
    localparam logic [funct_w-1:0] fn_jr  = 6'b001000;

endpackage
